// File: clic_pkg.sv
/*
 * Sizes and types shared by the whole CLIC interrupt path
 * Level is always the full 8 bits, there is no nmbits encoding
 * hgeie holds one enable bit per VS id, so its width follows VsidW
 */
package clic_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int unsigned NumSrc = 16;          // Interrupt sources
  localparam int unsigned IdW    = 4;           // Source id width
  localparam int unsigned Xlen   = 32;          // Cause word width
  localparam int unsigned VsidW  = 6;           // VS id width
  localparam int unsigned LvlW   = 8;           // Interrupt level width
  localparam int unsigned NumVs  = 2 ** VsidW;  // One hgeie bit per VS id

  // Cause word layout, level sits in bits 23:16 like mintstatus.mil
  localparam int unsigned CausePadHiW = Xlen - 1 - LvlW - 16;  // Between flag and level
  localparam int unsigned CausePadLoW = 16 - IdW;              // Between level and id

  // --------------------------------------------------------------------------
  // Privilege and hart state
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  typedef struct packed {
    logic [LvlW-1:0] mil;   // M-mode active level
    logic [LvlW-1:0] sil;   // S-mode active level
    logic [LvlW-1:0] vsil;  // VS-mode active level
  } intstatus_t;

  typedef struct packed {
    logic             sie;    // S-mode global enable
    logic             sgeie;  // Guest external irq enable (hie)
    logic [VsidW-1:0] vgein;  // VS currently running
    logic [NumVs-1:0] hgeie;  // Per-VS guest external enable
  } irq_ctrl_t;

  typedef struct packed {
    logic [LvlW-1:0] mintthresh;
    logic [LvlW-1:0] sintthresh;
    logic [LvlW-1:0] vsintthresh;
  } thresh_t;

  // --------------------------------------------------------------------------
  // Source config and offered interrupt
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic             ie;     // Source enable
    logic [LvlW-1:0]  level;
    priv_lvl_e        priv;   // Target mode, M or S
    logic             v;      // Delegated to a VS
    logic [VsidW-1:0] vsid;   // Target VS
  } src_cfg_t;

  typedef struct packed {
    logic             valid;
    logic [IdW-1:0]   id;
    logic [LvlW-1:0]  level;
    priv_lvl_e        priv;
    logic             v;
    logic [VsidW-1:0] vsid;
  } clic_irq_t;

  // --------------------------------------------------------------------------
  // mcause word, field view and raw view of the same bits
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic                   irq;     // Top bit, interrupt flag
    logic [CausePadHiW-1:0] pad_hi;
    logic [LvlW-1:0]        level;
    logic [CausePadLoW-1:0] pad_lo;
    logic [IdW-1:0]         id;
  } cause_fields_t;

  typedef union packed {
    logic [Xlen-1:0] raw;
    cause_fields_t   fields;
  } cause_u;

endpackage

// File: clic_gateway.sv
/*
 * Input side, every source is a one-cycle pulse latched as pending
 * Edge and level trigger modes are not modelled
 * A pulse in the same cycle as the claim of its source wins
 */
`timescale 1ns/1ps

module clic_gateway (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [clic_pkg::NumSrc-1:0]  src_pulse_i,    // One-cycle source pulses
  input  logic                         claim_valid_i,  // From trap port
  input  logic [clic_pkg::IdW-1:0]     claim_id_i,
  output logic [clic_pkg::NumSrc-1:0]  pending_o
);

  logic [clic_pkg::NumSrc-1:0] claim_hit;  // One-hot claim
  logic [clic_pkg::NumSrc-1:0] pending_d;
  logic [clic_pkg::NumSrc-1:0] pending_q;

  // --------------------------------------------------------------------------
  // Claim decode
  // --------------------------------------------------------------------------
  always_comb begin : claim_decode
    claim_hit = '0;
    if (claim_valid_i) begin
      claim_hit[claim_id_i] = 1'b1;
    end
  end

  // Set dominates clear
  assign pending_d = src_pulse_i | (pending_q & ~claim_hit);

  // --------------------------------------------------------------------------
  // Pending flops
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  assign pending_o = pending_q;

endmodule

// File: clic_arbiter.sv
/*
 * Picks the pending and enabled source with the highest level
 * Ties go to the lowest id
 * The offer is only replaced through the kill request/ack pair
 */
`timescale 1ns/1ps

module clic_arbiter (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [clic_pkg::NumSrc-1:0]               pending_i,
  input  clic_pkg::src_cfg_t [clic_pkg::NumSrc-1:0] src_cfg_i,
  input  logic                                      claim_valid_i,  // Ready, drops the offer
  input  logic                                      kill_ack_i,
  output clic_pkg::clic_irq_t                       offer_o,
  output logic                                      kill_req_o
);

  clic_pkg::clic_irq_t cand;        // Best source this cycle
  clic_pkg::clic_irq_t offer_q;
  logic                offer_live;  // Offered source still pending and enabled
  logic                cand_higher; // Candidate strictly above the offer

  // --------------------------------------------------------------------------
  // Candidate search
  // --------------------------------------------------------------------------
  always_comb begin : cand_search
    cand = '0;
    for (int unsigned i = 0; i < clic_pkg::NumSrc; i++) begin
      if (pending_i[i] && src_cfg_i[i].ie) begin
        // Strict compare, an equal level keeps the lower id
        if (!cand.valid || (src_cfg_i[i].level > cand.level)) begin
          cand.valid = 1'b1;
          cand.id    = i[clic_pkg::IdW-1:0];
          cand.level = src_cfg_i[i].level;
          cand.priv  = src_cfg_i[i].priv;
          cand.v     = src_cfg_i[i].v;
          cand.vsid  = src_cfg_i[i].vsid;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Kill request
  // --------------------------------------------------------------------------
  assign offer_live  = pending_i[offer_q.id] & src_cfg_i[offer_q.id].ie;
  assign cand_higher = cand.valid & (cand.level > offer_q.level);

  // Preempt by a higher level, or withdraw a stale offer
  assign kill_req_o = offer_q.valid & (cand_higher | ~offer_live);

  // --------------------------------------------------------------------------
  // Offer register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offer_q <= '0;
    end else if (claim_valid_i) begin
      offer_q.valid <= 1'b0;  // Taken by the core
    end else if (!offer_q.valid) begin
      offer_q <= cand;        // Empty, load whatever is best
    end else if (kill_req_o && kill_ack_i) begin
      offer_q <= cand;        // Swap, may also empty
    end
  end

  assign offer_o = offer_q;

endmodule

// File: clic_irq_filter.sv
/*
 * Acceptance filter between arbiter and trap port
 * Thresholds are max(intthresh, mintstatus) per mode
 * Virtual irqs seen in HS or plain U are ignored
 * A kill is only acked when nothing is in flight
 */
`timescale 1ns/1ps

module clic_irq_filter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  clic_pkg::priv_lvl_e     priv_lvl_i,    // Current hart mode
  input  logic                    v_i,           // Hart virtualized
  input  clic_pkg::irq_ctrl_t     irq_ctrl_i,
  input  clic_pkg::thresh_t       thresh_i,
  input  clic_pkg::intstatus_t    mintstatus_i,
  input  clic_pkg::clic_irq_t     offer_i,
  input  logic                    ready_i,       // Claim from trap port
  input  logic                    kill_req_i,
  output logic                    kill_ack_o,
  output logic                    accept_req_o,
  output clic_pkg::cause_u        cause_o,
  output clic_pkg::priv_lvl_e     priv_o,
  output logic                    v_o
);

  logic [clic_pkg::LvlW-1:0] eff_mthresh;
  logic [clic_pkg::LvlW-1:0] eff_sthresh;
  logic [clic_pkg::LvlW-1:0] eff_vsthresh;
  logic                      own_vs;       // Irq targets the running VS
  logic                      guest_ext;    // Other VS, trap to hypervisor
  logic                      inflight_d;
  logic                      inflight_q;

  function automatic logic [clic_pkg::LvlW-1:0] lvl_max(
    input logic [clic_pkg::LvlW-1:0] a,
    input logic [clic_pkg::LvlW-1:0] b
  );
    return (a > b) ? a : b;
  endfunction

  // --------------------------------------------------------------------------
  // Effective thresholds
  // --------------------------------------------------------------------------
  assign eff_mthresh  = lvl_max(thresh_i.mintthresh, mintstatus_i.mil);
  assign eff_sthresh  = lvl_max(thresh_i.sintthresh, mintstatus_i.sil);
  assign eff_vsthresh = lvl_max(thresh_i.vsintthresh, mintstatus_i.vsil);

  assign own_vs    = (offer_i.vsid == irq_ctrl_i.vgein);
  assign guest_ext = irq_ctrl_i.sgeie & irq_ctrl_i.hgeie[offer_i.vsid];

  // --------------------------------------------------------------------------
  // Acceptance
  // --------------------------------------------------------------------------
  always_comb begin : accept
    accept_req_o = 1'b0;
    v_o          = 1'b0;
    unique case (priv_lvl_i)
      clic_pkg::PRIV_M: begin
        if (offer_i.priv == clic_pkg::PRIV_M) begin
          accept_req_o = offer_i.valid & (offer_i.level > eff_mthresh);
        end
      end
      clic_pkg::PRIV_S: begin
        if (offer_i.priv == clic_pkg::PRIV_M) begin
          accept_req_o = offer_i.valid;  // M always preempts S
        end else if (offer_i.priv == clic_pkg::PRIV_S) begin
          if (!offer_i.v) begin
            // Host S irq, sie implied while in VS
            accept_req_o = offer_i.valid & (offer_i.level > eff_sthresh)
                           & (v_i | irq_ctrl_i.sie);
          end else if (v_i && own_vs) begin
            accept_req_o = offer_i.valid & (offer_i.level > eff_vsthresh) & irq_ctrl_i.sie;
            v_o          = 1'b1;
          end else if (v_i) begin
            accept_req_o = offer_i.valid & guest_ext;
          end
          // Virtual irq in HS is dropped
        end
      end
      clic_pkg::PRIV_U: begin
        if (offer_i.priv == clic_pkg::PRIV_M) begin
          accept_req_o = offer_i.valid;
        end else if (offer_i.priv == clic_pkg::PRIV_S) begin
          if (!offer_i.v) begin
            accept_req_o = offer_i.valid;  // Host S, sie implied below S
          end else if (v_i && own_vs) begin
            accept_req_o = offer_i.valid;  // VU, own guest
            v_o          = 1'b1;
          end else if (v_i) begin
            accept_req_o = offer_i.valid & guest_ext;
          end
          // Virtual irq in plain U is dropped
        end
      end
      default: ;
    endcase
  end

  assign priv_o = offer_i.priv;

  // Cause packing through the field view
  always_comb begin : cause_pack
    cause_o              = '0;
    cause_o.fields.irq   = 1'b1;
    cause_o.fields.level = offer_i.level;
    cause_o.fields.id    = offer_i.id;
  end

  // --------------------------------------------------------------------------
  // Kill control
  // --------------------------------------------------------------------------
  assign kill_ack_o = kill_req_i & ~inflight_q & ~accept_req_o;
  assign inflight_d = inflight_q ? ~(ready_i | kill_ack_o) : accept_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

// File: clic_trap_port.sv
/*
 * One-entry holding register toward the core
 * irq_req_o stays high until irq_taken_i, then a one-cycle claim is sent
 * A taken pulse with nothing held is dropped
 */
`timescale 1ns/1ps

module clic_trap_port (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       accept_req_i,  // Filter accepts the offer
  input  clic_pkg::cause_u           cause_i,
  input  clic_pkg::priv_lvl_e        priv_i,
  input  logic                       v_i,
  input  logic                       irq_taken_i,   // Core entered the trap
  output logic                       irq_req_o,
  output clic_pkg::cause_u           irq_cause_o,
  output clic_pkg::priv_lvl_e        irq_priv_o,
  output logic                       irq_v_o,
  output logic                       claim_valid_o,
  output logic [clic_pkg::IdW-1:0]   claim_id_o
);

  logic                full_q;   // Entry occupied
  logic                load;
  clic_pkg::cause_u    cause_q;
  clic_pkg::priv_lvl_e priv_q;
  logic                v_q;

  assign load = ~full_q & accept_req_i;  // Only latch when empty

  // --------------------------------------------------------------------------
  // Occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= ~irq_taken_i;  // Hold under back-pressure
    end else begin
      full_q <= accept_req_i;
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      cause_q <= cause_i;
      priv_q  <= priv_i;
      v_q     <= v_i;
    end
  end

  // --------------------------------------------------------------------------
  // Core side and claim
  // --------------------------------------------------------------------------
  assign irq_req_o   = full_q;
  assign irq_cause_o = cause_q;
  assign irq_priv_o  = priv_q;
  assign irq_v_o     = v_q;

  assign claim_valid_o = full_q & irq_taken_i;    // One cycle per taken pulse
  assign claim_id_o    = cause_q.fields.id;       // Id back out of the cause

endmodule

// File: clic_top.sv
/*
 * Hart-side CLIC interrupt path, gateway to arbiter to filter to trap port
 * Config, thresholds and hart state are plain inputs, no CSR bus
 * No selective hardware vectoring
 */
`timescale 1ns/1ps

module clic_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [clic_pkg::NumSrc-1:0]               src_pulse_i,
  input  clic_pkg::src_cfg_t [clic_pkg::NumSrc-1:0] src_cfg_i,
  input  clic_pkg::priv_lvl_e                       priv_lvl_i,
  input  logic                                      v_i,
  input  clic_pkg::irq_ctrl_t                       irq_ctrl_i,
  input  clic_pkg::thresh_t                         thresh_i,
  input  clic_pkg::intstatus_t                      mintstatus_i,
  input  logic                                      irq_taken_i,
  output logic                                      irq_req_o,
  output clic_pkg::cause_u                          irq_cause_o,
  output clic_pkg::priv_lvl_e                       irq_priv_o,
  output logic                                      irq_v_o
);

  logic [clic_pkg::NumSrc-1:0] pending;
  clic_pkg::clic_irq_t         offer;
  logic                        kill_req;
  logic                        kill_ack;
  logic                        accept_req;
  clic_pkg::cause_u            acc_cause;   // Cause of the accepted offer
  clic_pkg::priv_lvl_e         acc_priv;
  logic                        acc_v;
  logic                        claim_valid; // Also the filter's ready
  logic [clic_pkg::IdW-1:0]    claim_id;

  clic_gateway u_gateway (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .src_pulse_i   (src_pulse_i),
    .claim_valid_i (claim_valid),
    .claim_id_i    (claim_id),
    .pending_o     (pending)
  );

  clic_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pending_i     (pending),
    .src_cfg_i     (src_cfg_i),
    .claim_valid_i (claim_valid),
    .kill_ack_i    (kill_ack),
    .offer_o       (offer),
    .kill_req_o    (kill_req)
  );

  clic_irq_filter u_filter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .priv_lvl_i   (priv_lvl_i),
    .v_i          (v_i),
    .irq_ctrl_i   (irq_ctrl_i),
    .thresh_i     (thresh_i),
    .mintstatus_i (mintstatus_i),
    .offer_i      (offer),
    .ready_i      (claim_valid),
    .kill_req_i   (kill_req),
    .kill_ack_o   (kill_ack),
    .accept_req_o (accept_req),
    .cause_o      (acc_cause),
    .priv_o       (acc_priv),
    .v_o          (acc_v)
  );

  clic_trap_port u_trap_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_req_i  (accept_req),
    .cause_i       (acc_cause),
    .priv_i        (acc_priv),
    .v_i           (acc_v),
    .irq_taken_i   (irq_taken_i),
    .irq_req_o     (irq_req_o),
    .irq_cause_o   (irq_cause_o),
    .irq_priv_o    (irq_priv_o),
    .irq_v_o       (irq_v_o),
    .claim_valid_o (claim_valid),
    .claim_id_o    (claim_id)
  );

endmodule

// File: tb_clic_asserts.sv
/*
 * Protocol checks bound into clic_top
 * Checks are off while reset is low
 */
`timescale 1ns/1ps

module tb_clic_asserts (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        irq_req_i,
  input logic [31:0] irq_cause_i,
  input logic        irq_taken_i,
  input logic        kill_req_i,
  input logic        kill_ack_i,
  input logic        claim_valid_i
);

  // Request and cause held until the core takes it
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_i && !irq_taken_i |=> irq_req_i && $stable(irq_cause_i))
    else $error("irq_req_o or its cause changed before taken");

  // A kill is only acked with nothing held toward the core
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kill_ack_i |-> kill_req_i && !irq_req_i)
    else $error("kill_ack without kill_req or with an irq in flight");

  claim_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    claim_valid_i |=> !claim_valid_i)
    else $error("claim_valid longer than one cycle");

endmodule

bind clic_top tb_clic_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .irq_req_i     (irq_req_o),
  .irq_cause_i   (irq_cause_o),
  .irq_taken_i   (irq_taken_i),
  .kill_req_i    (kill_req),
  .kill_ack_i    (kill_ack),
  .claim_valid_i (claim_valid)
);

// File: tb_clic.sv
/*
 * Directed testbench for clic_top, one task per behavior
 * Expected acceptance and cause come from a model of the CLIC rules
 * Inputs change on the rising edge, outputs are sampled on the falling edge
 */
`timescale 1ns/1ps

module tb_clic;

  logic                                      clk_i;
  logic                                      rst_ni;
  logic [clic_pkg::NumSrc-1:0]               src_pulse;
  clic_pkg::src_cfg_t [clic_pkg::NumSrc-1:0] src_cfg;
  clic_pkg::priv_lvl_e                       priv_lvl;
  logic                                      virt;      // Hart in VS/VU
  clic_pkg::irq_ctrl_t                       irq_ctrl;
  clic_pkg::thresh_t                         thresh;
  clic_pkg::intstatus_t                      mstat;
  logic                                      irq_taken;
  logic                                      irq_req;
  clic_pkg::cause_u                          irq_cause;
  clic_pkg::priv_lvl_e                       irq_priv;
  logic                                      irq_v;

  clic_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .src_pulse_i  (src_pulse),
    .src_cfg_i    (src_cfg),
    .priv_lvl_i   (priv_lvl),
    .v_i          (virt),
    .irq_ctrl_i   (irq_ctrl),
    .thresh_i     (thresh),
    .mintstatus_i (mstat),
    .irq_taken_i  (irq_taken),
    .irq_req_o    (irq_req),
    .irq_cause_o  (irq_cause),
    .irq_priv_o   (irq_priv),
    .irq_v_o      (irq_v)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
  endtask

  // --------------------------------------------------------------------------
  // Reference model of the acceptance rules
  // --------------------------------------------------------------------------
  function automatic bit model_accept(input int id, output bit vflag);
    clic_pkg::src_cfg_t c;
    logic [7:0]         em;
    logic [7:0]         es;
    logic [7:0]         evs;
    c     = src_cfg[id];
    vflag = 1'b0;
    em    = (thresh.mintthresh > mstat.mil) ? thresh.mintthresh : mstat.mil;
    es    = (thresh.sintthresh > mstat.sil) ? thresh.sintthresh : mstat.sil;
    evs   = (thresh.vsintthresh > mstat.vsil) ? thresh.vsintthresh : mstat.vsil;
    if (priv_lvl == clic_pkg::PRIV_M) return (c.priv == clic_pkg::PRIV_M) && (c.level > em);
    if (c.priv == clic_pkg::PRIV_M) return 1'b1;    // M beats S and U
    if (!c.v) return (priv_lvl == clic_pkg::PRIV_U) || ((c.level > es) && (virt || irq_ctrl.sie));
    if (!virt) return 1'b0;                         // Virtual irq in HS or plain U
    if (c.vsid == irq_ctrl.vgein) begin
      vflag = 1'b1;
      return (priv_lvl == clic_pkg::PRIV_U) || ((c.level > evs) && irq_ctrl.sie);
    end
    return irq_ctrl.sgeie && irq_ctrl.hgeie[c.vsid];
  endfunction

  // Flag, 7 zeros, level, 12 zeros, id
  function automatic logic [31:0] model_cause(input int id);
    return {1'b1, 7'd0, src_cfg[id].level, 12'd0, id[3:0]};
  endfunction

  // --------------------------------------------------------------------------
  // Driving helpers
  // --------------------------------------------------------------------------
  task automatic reset_dut();
    @(posedge clk_i);
    rst_ni    <= 1'b0;
    src_cfg   <= '0;
    src_pulse <= '0;
    irq_taken <= 1'b0;
    irq_ctrl  <= '0;
    thresh    <= '0;
    mstat     <= '0;
    virt      <= 1'b0;
    priv_lvl  <= clic_pkg::PRIV_M;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!irq_req) else fail_run("irq_req_o high after reset");
  endtask

  task automatic set_src(input int id, input clic_pkg::priv_lvl_e p, input logic [7:0] lvl,
                         input logic vv, input logic [5:0] vsid);
    @(posedge clk_i);
    src_cfg[id] <= '{ie: 1'b1, level: lvl, priv: p, v: vv, vsid: vsid};
  endtask

  task automatic pulse(input logic [clic_pkg::NumSrc-1:0] mask);
    @(posedge clk_i);
    src_pulse <= mask;
    @(posedge clk_i);
    src_pulse <= '0;
  endtask

  task automatic take();
    @(posedge clk_i);
    irq_taken <= 1'b1;
    @(posedge clk_i);
    irq_taken <= 1'b0;
    @(negedge clk_i);
    assert (!irq_req) else fail_run("irq_req_o still high one cycle after taken");
  endtask

  // Waits for a request, checks it against the model, then takes it
  task automatic expect_irq(input int id, input int lat);
    bit vf;
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      assert (n <= 20) else fail_run("Timed out waiting for irq_req_o");
    end while (!irq_req);
    // Model sees the same settled inputs as the DUT
    assert (model_accept(id, vf)) else fail_run("Model rejects a source expected to be taken");
    if (lat > 0) begin
      assert (n == lat)
        else fail_run($sformatf("Error: irq latency got %h expected %h", n, lat));
    end
    assert (irq_cause.raw == model_cause(id))
      else fail_run($sformatf("Error: irq_cause_o got %h expected %h",
                              irq_cause.raw, model_cause(id)));
    assert (irq_v == vf)
      else fail_run($sformatf("Error: irq_v_o got %h expected %h", irq_v, vf));
    assert (irq_priv == src_cfg[id].priv)
      else fail_run($sformatf("Error: irq_priv_o got %h expected %h",
                              irq_priv, src_cfg[id].priv));
    take();
  endtask

  task automatic expect_none(input int id);
    bit vf;
    assert (!model_accept(id, vf)) else fail_run("Model accepts a source expected to be ignored");
    repeat (10) begin
      @(negedge clk_i);
      assert (!irq_req) else fail_run("irq_req_o raised when no interrupt may be taken");
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_m_thresh();
    reset_dut();
    @(posedge clk_i);
    thresh.mintthresh <= 8'h40;
    mstat.mil         <= 8'h50;  // Effective M threshold 0x50
    set_src(1, clic_pkg::PRIV_M, 8'h4f, 1'b0, 6'd0);
    set_src(2, clic_pkg::PRIV_M, 8'h50, 1'b0, 6'd0);
    set_src(3, clic_pkg::PRIV_M, 8'h51, 1'b0, 6'd0);
    pulse(16'h0002);
    expect_none(1);
    pulse(16'h0004);
    expect_none(2);
    pulse(16'h0008);
    expect_irq(3, 3);
  endtask

  task automatic test_priv_rules();
    reset_dut();
    @(posedge clk_i);
    priv_lvl <= clic_pkg::PRIV_S;
    thresh   <= '1;
    mstat    <= '1;
    set_src(1, clic_pkg::PRIV_M, 8'h01, 1'b0, 6'd0);
    pulse(16'h0002);
    expect_irq(1, 3);
    @(posedge clk_i);
    priv_lvl <= clic_pkg::PRIV_U;  // sie stays low
    set_src(2, clic_pkg::PRIV_S, 8'h10, 1'b0, 6'd0);
    pulse(16'h0004);
    expect_irq(2, 3);
    @(posedge clk_i);
    priv_lvl     <= clic_pkg::PRIV_S;
    thresh       <= '0;
    mstat        <= '0;
    irq_ctrl.sie <= 1'b1;  // VS path would open if v_i were ignored
    set_src(3, clic_pkg::PRIV_S, 8'hf0, 1'b1, 6'd0);
    pulse(16'h0008);
    expect_none(3);
  endtask

  task automatic test_vs_routing();
    reset_dut();
    @(posedge clk_i);
    priv_lvl           <= clic_pkg::PRIV_S;
    virt               <= 1'b1;
    irq_ctrl.sie       <= 1'b1;
    irq_ctrl.vgein     <= 6'd5;
    thresh.vsintthresh <= 8'h20;
    set_src(4, clic_pkg::PRIV_S, 8'h30, 1'b1, 6'd5);
    pulse(16'h0010);
    expect_irq(4, 3);
    set_src(5, clic_pkg::PRIV_S, 8'h30, 1'b1, 6'd9);
    pulse(16'h0020);
    expect_none(5);
    @(posedge clk_i);
    irq_ctrl.sgeie    <= 1'b1;
    irq_ctrl.hgeie[9] <= 1'b1;
    expect_irq(5, 0);  // Goes to the hypervisor, irq_v_o low
  endtask

  task automatic test_arbitration();
    reset_dut();
    set_src(7, clic_pkg::PRIV_M, 8'h40, 1'b0, 6'd0);
    set_src(2, clic_pkg::PRIV_M, 8'h60, 1'b0, 6'd0);
    set_src(9, clic_pkg::PRIV_M, 8'h60, 1'b0, 6'd0);
    pulse(16'h0284);
    expect_irq(2, 3);  // Tie at 0x60, lower id first
    expect_irq(9, 0);
    expect_irq(7, 0);
    repeat (10) begin
      @(negedge clk_i);
      assert (!irq_req) else fail_run("A claimed source was delivered again");
    end
  endtask

  task automatic test_kill();
    reset_dut();
    @(posedge clk_i);
    thresh.mintthresh <= 8'h50;
    set_src(3, clic_pkg::PRIV_M, 8'h30, 1'b0, 6'd0);
    set_src(6, clic_pkg::PRIV_M, 8'h70, 1'b0, 6'd0);
    pulse(16'h0008);
    expect_none(3);
    pulse(16'h0040);
    expect_irq(6, 3);  // Preempts the stuck offer
    @(posedge clk_i);
    thresh.mintthresh <= 8'h10;
    expect_irq(3, 0);
  endtask

  task automatic test_backpressure();
    logic [31:0] held;
    reset_dut();
    set_src(11, clic_pkg::PRIV_M, 8'ha5, 1'b0, 6'd0);
    set_src(12, clic_pkg::PRIV_M, 8'hf0, 1'b0, 6'd0);
    pulse(16'h0800);
    repeat (4) @(negedge clk_i);
    assert (irq_req) else fail_run("irq_req_o not raised for source 11");
    held = irq_cause.raw;
    assert (held == 32'h80a5000b && held == model_cause(11))
      else fail_run($sformatf("Error: irq_cause_o got %h expected %h", held, model_cause(11)));
    pulse(16'h1000);  // Higher source must not disturb the held entry
    repeat (8) begin
      @(negedge clk_i);
      assert (irq_req && irq_cause.raw == held)
        else fail_run($sformatf("Error: irq_cause_o got %h expected %h", irq_cause.raw, held));
    end
    take();
    expect_irq(12, 0);
  endtask

  initial begin
    rst_ni    = 1'b0;
    src_pulse = '0;
    src_cfg   = '0;
    priv_lvl  = clic_pkg::PRIV_M;
    virt      = 1'b0;
    irq_ctrl  = '0;
    thresh    = '0;
    mstat     = '0;
    irq_taken = 1'b0;
    test_m_thresh();
    test_priv_rules();
    test_vs_routing();
    test_arbitration();
    test_kill();
    test_backpressure();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: sim.f
clic_pkg.sv
clic_gateway.sv
clic_arbiter.sv
clic_irq_filter.sv
clic_trap_port.sv
clic_top.sv
tb_clic_asserts.sv
tb_clic.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_clic
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
